//--- include/lsu_macros.svh
// Sizing macros and access size codes for the load/store unit
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// Store buffer depth, any power of two from 2 up
`define ST_BUF_NUM_ENTRIES 8

`define ADDR_W 64 // Address bus width
`define DATA_W 64 // Data bus width

// Scalar size codes, log2 of the byte count in the low bits
`define SIZE_B   4'b0000
`define SIZE_H   4'b0001
`define SIZE_W   4'b0010
`define SIZE_D   4'b0011

// Vector access sizes
`define SIZE_V16 4'b1000
`define SIZE_V32 4'b1001
`define SIZE_V64 4'b1010

`endif

//--- hdl/lsu_pkg.sv
// Shared vector types and the memory port FSM states
`include "lsu_macros.svh"

package lsu_pkg;

    // Full width address as seen by memory
    typedef logic [`ADDR_W-1:0] addr_t;

    // One data word, stores and load returns
    typedef logic [`DATA_W-1:0] data_t;

    // Access size code, scalar or vector
    typedef logic [3:0] mem_size_t;

    // Store buffer entry index
    typedef logic [$clog2(`ST_BUF_NUM_ENTRIES)-1:0] st_ptr_t;

    // Occupancy, one bit more than the index so a full buffer fits
    typedef logic [$clog2(`ST_BUF_NUM_ENTRIES):0] st_cnt_t;

    // Memory port owner
    typedef enum logic [1:0] {
        PORT_IDLE,  // Nothing outstanding
        PORT_LOAD,  // Read request waiting for ack
        PORT_STORE  // Head store waiting for ack
    } port_state_t;

endpackage

//--- hdl/store_buffer.sv
// Circular store queue with flush and full/empty flags
// Size-aware load collision check against every buffered store
`timescale 1ns/1ps
`include "lsu_macros.svh"

module store_buffer import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      st_valid_i,     // Store strobe from the pipeline
    input  addr_t     st_addr_i,
    input  data_t     st_data_i,
    input  mem_size_t st_size_i,
    input  logic      st_flush_i,     // Drop every entry at the next edge
    input  logic      head_advance_i, // Head store has been acked
    input  addr_t     ld_addr_i,      // Pending load to check
    input  mem_size_t ld_size_i,
    output logic      head_valid_o,
    output addr_t     head_addr_o,
    output data_t     head_data_o,
    output mem_size_t head_size_o,
    output logic      st_empty_o,
    output logic      st_full_o,
    output logic      ld_collision_o
);

    st_ptr_t head_q; // Oldest entry
    st_ptr_t tail_q; // Next free entry
    st_cnt_t count_q;

    logic wr_en;
    logic adv_en;

    // Entry storage
    addr_t     addr_q [`ST_BUF_NUM_ENTRIES];
    data_t     data_q [`ST_BUF_NUM_ENTRIES];
    mem_size_t size_q [`ST_BUF_NUM_ENTRIES];
    logic [`ST_BUF_NUM_ENTRIES-1:0] valid_q;

    // log2 of the alignment block an access covers
    function automatic logic [2:0] size_gran(input mem_size_t size);
        logic [2:0] gran;
        case (size)
            `SIZE_V64: gran = 3'd6;
            `SIZE_V32: gran = 3'd5;
            `SIZE_V16: gran = 3'd4;
            default:   gran = {1'b0, size[1:0]}; // Scalar sizes 1 to 8 bytes
        endcase
        return gran;
    endfunction

    assign wr_en  = st_valid_i & (count_q < st_cnt_t'(`ST_BUF_NUM_ENTRIES));
    assign adv_en = head_advance_i & (count_q != '0); // Late ack after flush is dropped

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (st_flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + st_ptr_t'(adv_en);  // Wraps on power of two depth
            tail_q  <= tail_q + st_ptr_t'(wr_en);
            count_q <= count_q + st_cnt_t'(wr_en) - st_cnt_t'(adv_en);
        end
    end

    // Per-entry valid bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (st_flush_i) begin
            valid_q <= '0;
        end else begin
            if (wr_en) begin
                valid_q[tail_q] <= 1'b1;
            end
            if (adv_en) begin
                valid_q[head_q] <= 1'b0;  // Slots differ unless empty or full
            end
        end
    end

    // Payload written at the tail
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            addr_q[tail_q] <= st_addr_i;
            data_q[tail_q] <= st_data_i;
            size_q[tail_q] <= st_size_i;
        end
    end

    // Compare the page offset above the coarser of the two granularities
    always_comb begin : collision_detector
        logic [2:0]  ld_gran;
        logic [2:0]  st_gran;
        logic [11:0] cmp_mask;
        ld_collision_o = 1'b0;
        ld_gran        = size_gran(ld_size_i);
        for (int i = 0; i < `ST_BUF_NUM_ENTRIES; i++) begin
            st_gran  = size_gran(size_q[i]);
            cmp_mask = 12'hfff << ((st_gran > ld_gran) ? st_gran : ld_gran);
            if (valid_q[i] && (((addr_q[i][11:0] ^ ld_addr_i[11:0]) & cmp_mask) == '0)) begin
                ld_collision_o = 1'b1;
            end
        end
    end

    // Head entry for the port controller
    assign head_valid_o = (count_q != '0);
    assign head_addr_o  = addr_q[head_q];
    assign head_data_o  = data_q[head_q];
    assign head_size_o  = size_q[head_q];

    assign st_empty_o = (count_q == '0);
    // One slot of slack for a strobe already under way
    assign st_full_o  = (count_q >= st_cnt_t'(`ST_BUF_NUM_ENTRIES - 1)) | st_flush_i | ~rstn_i;

endmodule

//--- hdl/mem_port_ctrl.sv
// Memory port FSM, loads first unless they hit a buffered store
// Drains the store buffer head when no load can go
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_port_ctrl import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    // Load side of the pipeline
    input  logic      ld_valid_i,     // Held until ld_done_o
    input  addr_t     ld_addr_i,
    input  mem_size_t ld_size_i,
    input  logic      ld_collision_i, // Load overlaps a buffered store
    // Store buffer head
    input  logic      head_valid_i,
    input  addr_t     head_addr_i,
    input  data_t     head_data_i,
    input  mem_size_t head_size_i,
    output logic      head_advance_o, // Pops the head on store ack
    output logic      ld_done_o,
    output data_t     ld_data_o,
    // Memory port
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output data_t     mem_wdata_o,
    output mem_size_t mem_size_o,
    input  logic      mem_ack_i,
    input  data_t     mem_rdata_i
);

    port_state_t state_q;
    port_state_t state_d;

    logic ld_eligible;
    logic st_eligible;
    logic issue;
    logic ld_ack;

    logic      mem_req_q;
    logic      mem_we_q;
    addr_t     mem_addr_q;
    data_t     mem_wdata_q;
    mem_size_t mem_size_q;
    logic      ld_done_q;
    data_t     ld_data_q;

    // A load just finished is still on ld_valid_i during its done cycle
    assign ld_eligible = ld_valid_i & ~ld_collision_i & ~ld_done_q;
    assign st_eligible = head_valid_i & ~ld_eligible;  // Loads win
    assign issue       = (state_q == PORT_IDLE) & (ld_eligible | st_eligible);
    assign ld_ack      = (state_q == PORT_LOAD) & mem_ack_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            PORT_IDLE: begin
                if (ld_eligible) begin
                    state_d = PORT_LOAD;
                end else if (st_eligible) begin
                    state_d = PORT_STORE;
                end
            end
            PORT_LOAD, PORT_STORE: begin
                if (mem_ack_i) begin
                    state_d = PORT_IDLE; // Free to issue again next cycle
                end
            end
            default: state_d = PORT_IDLE;
        endcase
    end

    // Control registers
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= PORT_IDLE;
            mem_req_q <= 1'b0;
            mem_we_q  <= 1'b0;
            ld_done_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            ld_done_q <= ld_ack;            // One cycle after the read ack
            if (issue) begin
                mem_req_q <= 1'b1;
                mem_we_q  <= ~ld_eligible;
            end else if (mem_req_q && mem_ack_i) begin
                mem_req_q <= 1'b0;
                mem_we_q  <= 1'b0;
            end
        end
    end

    // Request payload, held steady until the ack
    always_ff @(posedge clk_i) begin
        if (issue) begin
            mem_addr_q  <= ld_eligible ? ld_addr_i : head_addr_i;
            mem_size_q  <= ld_eligible ? ld_size_i : head_size_i;
            mem_wdata_q <= head_data_i; // Ignored by memory on reads
        end
        if (ld_ack) begin
            ld_data_q <= mem_rdata_i;
        end
    end

    assign head_advance_o = (state_q == PORT_STORE) & mem_ack_i; // Entry leaves at this edge
    assign ld_done_o      = ld_done_q;
    assign ld_data_o      = ld_data_q;

    assign mem_req_o   = mem_req_q;
    assign mem_we_o    = mem_we_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;
    assign mem_size_o  = mem_size_q;

endmodule

//--- hdl/lsu_top.sv
// Memory stage top, store buffer plus memory port controller
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rstn_i,
    // Store side
    input  logic      st_valid_i,
    input  addr_t     st_addr_i,
    input  data_t     st_data_i,
    input  mem_size_t st_size_i,
    input  logic      st_flush_i,
    output logic      st_empty_o,
    output logic      st_full_o,
    // Load side
    input  logic      ld_valid_i,
    input  addr_t     ld_addr_i,
    input  mem_size_t ld_size_i,
    output logic      ld_done_o,
    output data_t     ld_data_o,
    // Memory port
    output logic      mem_req_o,
    output logic      mem_we_o,
    output addr_t     mem_addr_o,
    output data_t     mem_wdata_o,
    output mem_size_t mem_size_o,
    input  logic      mem_ack_i,
    input  data_t     mem_rdata_i
);

    logic      head_valid;
    addr_t     head_addr;
    data_t     head_data;
    mem_size_t head_size;
    logic      head_advance;  // Store acked by memory
    logic      ld_collision;  // Pending load hits a buffered store

    store_buffer store_buffer0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .st_valid_i     (st_valid_i),
        .st_addr_i      (st_addr_i),
        .st_data_i      (st_data_i),
        .st_size_i      (st_size_i),
        .st_flush_i     (st_flush_i),
        .head_advance_i (head_advance),
        .ld_addr_i      (ld_addr_i),
        .ld_size_i      (ld_size_i),
        .head_valid_o   (head_valid),
        .head_addr_o    (head_addr),
        .head_data_o    (head_data),
        .head_size_o    (head_size),
        .st_empty_o     (st_empty_o),
        .st_full_o      (st_full_o),
        .ld_collision_o (ld_collision)
    );

    mem_port_ctrl port_ctrl0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .ld_valid_i     (ld_valid_i),
        .ld_addr_i      (ld_addr_i),
        .ld_size_i      (ld_size_i),
        .ld_collision_i (ld_collision),
        .head_valid_i   (head_valid),
        .head_addr_i    (head_addr),
        .head_data_i    (head_data),
        .head_size_i    (head_size),
        .head_advance_o (head_advance),
        .ld_done_o      (ld_done_o),
        .ld_data_o      (ld_data_o),
        .mem_req_o      (mem_req_o),
        .mem_we_o       (mem_we_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_size_o     (mem_size_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i)
    );

endmodule

//--- dv/lsu_properties.sv
// Bound checks on the memory port handshake, load gating and reset values
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_properties import lsu_pkg::*; (
    input logic      clk_i,
    input logic      rstn_i,
    input logic      mem_req_o,
    input logic      mem_we_o,
    input addr_t     mem_addr_o,
    input data_t     mem_wdata_o,
    input mem_size_t mem_size_o,
    input logic      mem_ack_i,
    input logic      ld_done_o,
    input logic      ld_collision, // Internal to lsu_top
    input logic      st_empty_o,
    input logic      st_full_o
);

    int fail_cnt = 0; // Read by the testbench

    // Request frozen until memory answers
    req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o)
            && $stable(mem_wdata_o) && $stable(mem_size_o))
        else begin
            $error("memory request dropped or changed before its ack");
            fail_cnt++;
        end

    // A read only goes out if the cycle it was chosen had no collision
    ld_gated: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(mem_req_o) && !mem_we_o |-> !$past(ld_collision))
        else begin
            $error("load request issued while it collided with a buffered store");
            fail_cnt++;
        end

    reset_vals: assert property (@(posedge clk_i)
        !rstn_i |-> !mem_req_o && !mem_we_o && !ld_done_o && st_empty_o && st_full_o)
        else begin
            $error("outputs not at their reset values during reset");
            fail_cnt++;
        end

endmodule

bind lsu_top lsu_properties props0 (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_size_o   (mem_size_o),
    .mem_ack_i    (mem_ack_i),
    .ld_done_o    (ld_done_o),
    .ld_collision (ld_collision),
    .st_empty_o   (st_empty_o),
    .st_full_o    (st_full_o)
);

//--- dv/lsu_tb.sv
// Testbench for the load/store unit
// Memory model, store scoreboard, directed tests and watchdog
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb import lsu_pkg::*; ();

    localparam int NUM_TESTS = 5;
    localparam int DEPTH     = `ST_BUF_NUM_ENTRIES;

    typedef struct packed {
        addr_t     addr;
        data_t     data;
        mem_size_t size;
    } store_t;

    logic      clk_i = 1'b0;
    logic      rstn_i;
    logic      st_valid_i, st_flush_i, st_empty_o, st_full_o;
    logic      ld_valid_i, ld_done_o;
    logic      mem_req_o, mem_we_o, mem_ack_i;
    addr_t     st_addr_i, ld_addr_i, mem_addr_o;
    data_t     st_data_i, ld_data_o, mem_wdata_o, mem_rdata_i;
    mem_size_t st_size_i, ld_size_i, mem_size_o;

    data_t  mem [addr_t];  // Memory contents by address
    store_t st_q [$];      // Accepted stores not yet acked
    int     occ;           // Expected buffer occupancy
    bit     slow_mem;      // Long fixed latency so stores pile up
    int     errors;
    int     err_base;
    int     tests_run;
    int     tests_failed;

    always #10 clk_i = ~clk_i;

    lsu_top dut0 (.*);

    // Untouched memory reads back a word built from the whole address
    function automatic data_t fill_word(input addr_t a);
        return ~a ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    // log2 of the block an access covers
    function automatic int gran(input mem_size_t s);
        case (s)
            `SIZE_V64: return 6;
            `SIZE_V32: return 5;
            `SIZE_V16: return 4;
            default:   return int'(s[1:0]);
        endcase
    endfunction

    // Offset bits above the coarser granularity match
    function automatic bit overlaps(input addr_t la, input mem_size_t ls,
                                    input addr_t sa, input mem_size_t ss);
        int g;
        g = (gran(ls) > gran(ss)) ? gran(ls) : gran(ss);
        return (la[11:0] >> g) == (sa[11:0] >> g);
    endfunction

    function automatic int total_errors();
        return errors + dut0.props0.fail_cnt;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERROR at %0t ns: %s expected %0h got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Random ack latency, or a long one when stores must queue up
    initial begin : mem_model
        int unsigned lat;
        void'($urandom(17896));
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk_i);
            if (mem_req_o) begin
                lat = slow_mem ? DEPTH + 2 : $urandom_range(4, 1);
                repeat (lat - 1) @(negedge clk_i);
                mem_rdata_i = mem.exists(mem_addr_o) ? mem[mem_addr_o] : fill_word(mem_addr_o);
                if (mem_we_o) begin
                    mem[mem_addr_o] = mem_wdata_o;
                end
                mem_ack_i = 1'b1;
                @(negedge clk_i);
                mem_ack_i = 1'b0;
            end
        end
    end

    // Flags, store order and load gating, sampled at the rising edge
    always @(posedge clk_i) begin : scoreboard
        store_t exp;
        if (!rstn_i) begin
            occ = 0;
            st_q.delete();
        end else begin
            check_value("st_full_o", (occ >= DEPTH - 1) || st_flush_i, st_full_o);
            check_value("st_empty_o", occ == 0, st_empty_o);
            if (mem_req_o && mem_ack_i && mem_we_o) begin
                if (occ != 0) occ--; // Late ack after a flush pops nothing
                assert (st_q.size() != 0) else begin
                    $display("Store to %0h reached memory with no store pending", mem_addr_o);
                    errors++;
                end
                if (st_q.size() != 0) begin
                    exp = st_q.pop_front();
                    check_value("mem_addr_o", exp.addr, mem_addr_o);
                    check_value("mem_wdata_o", exp.data, mem_wdata_o);
                    check_value("mem_size_o", exp.size, mem_size_o);
                end
            end
            if (mem_req_o && mem_ack_i && !mem_we_o) begin
                foreach (st_q[i]) begin
                    assert (!overlaps(mem_addr_o, mem_size_o, st_q[i].addr, st_q[i].size)) else begin
                        $display("Load from %0h went out ahead of store to %0h", mem_addr_o,
                                 st_q[i].addr);
                        errors++;
                    end
                end
            end
            if (st_flush_i) begin
                occ = 0;
                // Only a store already on the port survives
                if (mem_req_o && mem_we_o && !mem_ack_i && st_q.size() != 0) begin
                    st_q = st_q[0:0];
                end else begin
                    st_q.delete();
                end
            end else if (st_valid_i && !st_full_o) begin
                st_q.push_back('{st_addr_i, st_data_i, st_size_i});
                occ++;
            end
        end
    end

    // Called on a falling edge, back to back gives one store per cycle
    task automatic push_store(input addr_t a, input data_t d, input mem_size_t s);
        while (st_full_o) @(negedge clk_i);
        st_valid_i = 1'b1;
        st_addr_i  = a;
        st_data_i  = d;
        st_size_i  = s;
        @(negedge clk_i);
        st_valid_i = 1'b0;
    endtask

    task automatic run_load(input addr_t a, input mem_size_t s, input data_t exp,
                            input bit stores_left);
        ld_valid_i = 1'b1;
        ld_addr_i  = a;
        ld_size_i  = s;
        do @(negedge clk_i); while (!ld_done_o);
        check_value("ld_data_o", exp, ld_data_o);
        if (stores_left) check_value("st_empty_o", 0, st_empty_o); // Load went first
        ld_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (!st_empty_o || mem_req_o) @(negedge clk_i);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (total_errors() == err_base) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, total_errors() - err_base);
        end
        err_base = total_errors();
    endtask

    initial begin : stimulus
        rstn_i     = 1'b0;
        st_valid_i = 1'b0;
        st_addr_i  = '0;
        st_data_i  = '0;
        st_size_i  = '0;
        st_flush_i = 1'b0;
        ld_valid_i = 1'b0;
        ld_addr_i  = '0;
        ld_size_i  = '0;
        slow_mem   = 1'b0;
        errors     = 0;
        err_base   = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);

        for (int i = 0; i < 8; i++) begin
            push_store(64'h1000 + 16 * i, 64'h1111_0000_0000_0000 + i, mem_size_t'(i % 4));
        end
        wait_idle();
        check_value("pending stores", 0, st_q.size());
        end_test("store order");

        // Load to a disjoint doubleword jumps the queue
        for (int i = 0; i < 5; i++) begin
            push_store(64'h2000 + 8 * i, 64'h2222_0000_0000_0000 + i, `SIZE_D);
        end
        run_load(64'h2100, `SIZE_D, fill_word(64'h2100), 1'b1);
        wait_idle();
        end_test("load bypass");

        slow_mem = 1'b1;
        push_store(64'h3000, 64'h3333_0000_0000_0001, `SIZE_D);
        push_store(64'h3208, 64'h3333_0000_0000_0002, `SIZE_D);
        run_load(64'h3208, `SIZE_W, 64'h3333_0000_0000_0002, 1'b0); // Word inside doubleword
        push_store(64'h34c0, 64'h3434_0000_0000_0003, `SIZE_V64);
        push_store(64'h34f8, 64'h3434_0000_0000_0004, `SIZE_B);     // Same 64 byte block
        run_load(64'h34c0, `SIZE_V64, 64'h3434_0000_0000_0003, 1'b0); // Waits for both
        wait_idle();
        end_test("load collision");

        for (int i = 0; i < DEPTH - 1; i++) begin
            push_store(64'h4000 + 8 * i, 64'h4444_0000_0000_0000 + i, `SIZE_D);
        end
        check_value("st_full_o", 1, st_full_o);
        push_store(64'h4100, 64'h4444_0000_0000_0100, `SIZE_W); // Held off by back-pressure
        push_store(64'h4108, 64'h4444_0000_0000_0108, `SIZE_W);
        wait_idle();
        check_value("pending stores", 0, st_q.size());
        end_test("full and empty");

        for (int i = 0; i < 4; i++) begin
            push_store(64'h5000 + 8 * i, 64'h5555_0000_0000_0000 + i, `SIZE_D);
        end
        while (!(mem_req_o && mem_we_o)) @(negedge clk_i);
        st_flush_i = 1'b1;
        @(negedge clk_i);
        st_flush_i = 1'b0;
        check_value("st_empty_o", 1, st_empty_o);
        wait_idle();
        slow_mem = 1'b0;
        end_test("flush");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(NUM_TESTS * 2000);
        $display("Watchdog expired after %0d ns with tests still running", NUM_TESTS * 2000);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
hdl/lsu_pkg.sv
hdl/store_buffer.sv
hdl/mem_port_ctrl.sv
hdl/lsu_top.sv
dv/lsu_properties.sv
dv/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - hdl/lsu_pkg.sv
      - hdl/store_buffer.sv
      - hdl/mem_port_ctrl.sv
      - hdl/lsu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/lsu_properties.sv
      - dv/lsu_tb.sv
